// ==== hdl/fetch_pkg.sv ====
package fetch_pkg;

  ////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////

  // Byte address width of the fetch path.
  localparam int unsigned AddrLen = 16;
  localparam int unsigned InstrLen = 32;

  // The ROM holds 16 words, so addresses wrap every 64 bytes.
  localparam int unsigned ImemAddrBits = 4;

  // Predictor table sizes, in index bits.
  localparam int unsigned BtbIndexBits = 3;
  localparam int unsigned BhtIndexBits = 4;

  ////////////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////////////

  // How the PC of a fetched instruction was chosen.
  typedef enum logic [1:0] {
    FETCH_PREFETCH = 2'd0,
    FETCH_PREDICT  = 2'd1,
    FETCH_REDIRECT = 2'd2
  } fetch_reason_e;

  // Resolved kind of an instruction, reported by the back end.
  // The low bit separates taken from untaken for conditional branches.
  typedef enum logic [1:0] {
    BRANCH_NONE    = 2'd0,
    BRANCH_UNTAKEN = 2'd1,
    BRANCH_TAKEN   = 2'd2,
    BRANCH_JUMP    = 2'd3
  } branch_type_e;

  ////////////////////////////////////////////////////////////////////
  // Bundles
  ////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic               valid;
    logic [AddrLen-1:0] pc;
  } imem_req_t;

  typedef struct packed {
    logic                valid;
    logic [InstrLen-1:0] instr;
  } imem_resp_t;

  typedef struct packed {
    branch_type_e       branch_type;
    logic [AddrLen-1:0] pc;
  } branch_info_t;

  typedef struct packed {
    logic [AddrLen-1:0]  pc;
    logic [InstrLen-1:0] instr;
    fetch_reason_e       reason;
  } fetched_instr_t;

endpackage

// ==== hdl/fetch_btb.sv ====
`timescale 1ns/1ps

module fetch_btb #(
  parameter int unsigned IndexWidth = 3
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          train_valid_i,
  input  fetch_pkg::branch_type_e       train_type_i,
  input  logic [fetch_pkg::AddrLen-1:0] train_pc_i,
  input  logic [fetch_pkg::AddrLen-1:0] train_target_i,
  input  logic [fetch_pkg::AddrLen-1:0] lookup_pc_i,
  output logic                          hit_o,
  output fetch_pkg::branch_type_e       type_o,
  output logic [fetch_pkg::AddrLen-1:0] target_o
);

  // The tag is everything above the word index.
  typedef struct packed {
    logic [fetch_pkg::AddrLen-IndexWidth-3:0] tag;
    fetch_pkg::branch_type_e                  btype;
    logic [fetch_pkg::AddrLen-1:0]            target;
  } btb_entry_t;

  logic [2**IndexWidth-1:0] valid_q;
  btb_entry_t               entry_q [2**IndexWidth];

  logic [IndexWidth-1:0] train_idx;
  logic [IndexWidth-1:0] lookup_idx;
  btb_entry_t            lookup_entry;
  logic                  lookup_hit;

  assign train_idx    = train_pc_i[IndexWidth+1:2];
  assign lookup_idx   = lookup_pc_i[IndexWidth+1:2];
  assign lookup_entry = entry_q[lookup_idx];
  assign lookup_hit   = valid_q[lookup_idx] &&
                        (lookup_entry.tag == lookup_pc_i[fetch_pkg::AddrLen-1:IndexWidth+2]);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      hit_o   <= 1'b0;
    end else begin
      if (train_valid_i) begin
        valid_q[train_idx] <= 1'b1;
      end
      hit_o <= lookup_hit;
    end
  end

  // A training write simply replaces whatever was in the slot.
  always_ff @(posedge clk_i) begin
    if (train_valid_i) begin
      entry_q[train_idx] <= '{
        tag:    train_pc_i[fetch_pkg::AddrLen-1:IndexWidth+2],
        btype:  train_type_i,
        target: train_target_i
      };
    end
    type_o   <= lookup_entry.btype;
    target_o <= lookup_entry.target;
  end

  // All instructions are 32-bit, so neither side should ever see a half-word PC.
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    train_valid_i |-> (train_pc_i[1:0] == 2'b00) && (train_target_i[1:0] == 2'b00));
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    lookup_pc_i[1:0] == 2'b00);

endmodule

// ==== hdl/fetch_bimodal.sv ====
`timescale 1ns/1ps

module fetch_bimodal #(
  parameter int unsigned IndexWidth = 4
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          train_valid_i,
  input  logic                          train_taken_i,
  input  logic [fetch_pkg::AddrLen-1:0] train_pc_i,
  input  logic [fetch_pkg::AddrLen-1:0] lookup_pc_i,
  output logic                          taken_o
);

  logic [1:0] ctr_q [2**IndexWidth];

  logic [IndexWidth-1:0] train_idx;
  logic [IndexWidth-1:0] lookup_idx;
  logic [1:0]            train_ctr;

  assign train_idx  = train_pc_i[IndexWidth+1:2];
  assign lookup_idx = lookup_pc_i[IndexWidth+1:2];
  assign train_ctr  = ctr_q[train_idx];

  // Counters start weakly not-taken and saturate at both ends.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < 2**IndexWidth; i++) begin
        ctr_q[i] <= 2'b01;
      end
    end else if (train_valid_i) begin
      if (train_taken_i && train_ctr != 2'b11) begin
        ctr_q[train_idx] <= train_ctr + 2'b01;
      end else if (!train_taken_i && train_ctr != 2'b00) begin
        ctr_q[train_idx] <= train_ctr - 2'b01;
      end
    end
  end

  // The upper bit is the prediction, held for the cycle after the lookup.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      taken_o <= 1'b0;
    end else begin
      taken_o <= ctr_q[lookup_idx][1];
    end
  end

endmodule

// ==== hdl/fetch_frontend.sv ====
`timescale 1ns/1ps

module fetch_frontend (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  output fetch_pkg::imem_req_t          imem_req_o,
  input  fetch_pkg::imem_resp_t         imem_resp_i,
  input  logic                          redirect_valid_i,
  input  logic [fetch_pkg::AddrLen-1:0] redirect_pc_i,
  input  fetch_pkg::branch_info_t       branch_info_i,
  output logic                          fetch_valid_o,
  input  logic                          fetch_ready_i,
  output fetch_pkg::fetched_instr_t     fetch_instr_o
);

  ////////////////////////////////////////////////////////////////////
  // Next PC
  ////////////////////////////////////////////////////////////////////

  // A redirect is a pulse, so hold it until a request can carry it.
  logic                          redirect_valid_q;
  logic [fetch_pkg::AddrLen-1:0] redirect_pc_q;

  // PC and reason of the most recent request.
  logic [fetch_pkg::AddrLen-1:0] pc_q;
  fetch_pkg::fetch_reason_e      reason_q;

  logic [fetch_pkg::AddrLen-1:0] pc_next;
  fetch_pkg::fetch_reason_e      reason_next;
  logic [fetch_pkg::AddrLen-1:0] lookup_pc;
  logic                          issue;

  logic                          btb_hit;
  fetch_pkg::branch_type_e       btb_type;
  logic [fetch_pkg::AddrLen-1:0] btb_target;
  logic                          bht_taken;
  logic                          predict_taken;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      // Start at PC 0 as if the back end had redirected there.
      redirect_valid_q <= 1'b1;
      redirect_pc_q    <= '0;
    end else if (redirect_valid_i) begin
      redirect_valid_q <= 1'b1;
      redirect_pc_q    <= redirect_pc_i;
    end else if (issue) begin
      redirect_valid_q <= 1'b0;
    end
  end

  // The predictor outputs describe pc_q, since they were looked up when it was chosen.
  assign predict_taken = btb_hit && (btb_type == fetch_pkg::BRANCH_JUMP || bht_taken);

  always_comb begin
    if (redirect_valid_q) begin
      pc_next     = redirect_pc_q;
      reason_next = fetch_pkg::FETCH_REDIRECT;
    end else if (predict_taken) begin
      pc_next     = btb_target;
      reason_next = fetch_pkg::FETCH_PREDICT;
    end else begin
      pc_next     = pc_q + fetch_pkg::AddrLen'(4);
      reason_next = fetch_pkg::FETCH_PREFETCH;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pc_q     <= '0;
      reason_q <= fetch_pkg::FETCH_PREFETCH;
    end else if (issue) begin
      pc_q     <= pc_next;
      reason_q <= reason_next;
    end
  end

  // Without a request the tables must keep describing the current PC.
  assign lookup_pc = issue ? pc_next : pc_q;

  ////////////////////////////////////////////////////////////////////
  // Predictors
  ////////////////////////////////////////////////////////////////////

  fetch_btb #(
    .IndexWidth (fetch_pkg::BtbIndexBits)
  ) btb (
    .clk_i,
    .rst_ni,
    .train_valid_i  (redirect_valid_i && (branch_info_i.branch_type inside
                     {fetch_pkg::BRANCH_TAKEN, fetch_pkg::BRANCH_JUMP})),
    .train_type_i   (branch_info_i.branch_type),
    .train_pc_i     (branch_info_i.pc),
    .train_target_i (redirect_pc_i),
    .lookup_pc_i    (lookup_pc),
    .hit_o          (btb_hit),
    .type_o         (btb_type),
    .target_o       (btb_target)
  );

  fetch_bimodal #(
    .IndexWidth (fetch_pkg::BhtIndexBits)
  ) bht (
    .clk_i,
    .rst_ni,
    .train_valid_i (redirect_valid_i && (branch_info_i.branch_type inside
                    {fetch_pkg::BRANCH_TAKEN, fetch_pkg::BRANCH_UNTAKEN})),
    .train_taken_i (branch_info_i.branch_type == fetch_pkg::BRANCH_TAKEN),
    .train_pc_i    (branch_info_i.pc),
    .lookup_pc_i   (lookup_pc),
    .taken_o       (bht_taken)
  );

  ////////////////////////////////////////////////////////////////////
  // Memory request and response buffering
  ////////////////////////////////////////////////////////////////////

  logic                      out_valid_q;
  fetch_pkg::fetched_instr_t out_data_q;
  logic                      skid_valid_q;
  fetch_pkg::fetched_instr_t skid_data_q;
  logic                      flush_q;
  logic                      out_load;
  logic                      resp_keep;
  logic                      skid_write;
  fetch_pkg::fetched_instr_t resp_item;

  // Only ask for a word when its answer is sure to find room next cycle.
  assign out_load   = !out_valid_q || fetch_ready_i;
  assign issue      = !skid_valid_q && out_load;
  assign imem_req_o = '{valid: issue, pc: pc_next};

  assign resp_keep  = imem_resp_i.valid && !flush_q && !redirect_valid_i;
  assign skid_write = resp_keep && !out_load;
  assign resp_item  = '{pc: pc_q, instr: imem_resp_i.instr, reason: reason_q};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_valid_q  <= 1'b0;
      skid_valid_q <= 1'b0;
      flush_q      <= 1'b0;
    end else begin
      // A request sent in the redirect cycle belongs to the old path.
      flush_q <= redirect_valid_i && issue;
      if (redirect_valid_i) begin
        out_valid_q  <= 1'b0;
        skid_valid_q <= 1'b0;
      end else if (out_load) begin
        out_valid_q  <= skid_valid_q || resp_keep;
        skid_valid_q <= 1'b0;
      end else if (skid_write) begin
        skid_valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (out_load) begin
      out_data_q <= skid_valid_q ? skid_data_q : resp_item;
    end
    if (skid_write) begin
      skid_data_q <= resp_item;
    end
  end

  assign fetch_valid_o = out_valid_q;
  assign fetch_instr_o = out_data_q;

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    skid_write |-> !skid_valid_q);
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    imem_resp_i.valid |-> $past(imem_req_o.valid));

endmodule

// ==== hdl/fetch_imem.sv ====
`timescale 1ns/1ps

module fetch_imem (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  fetch_pkg::imem_req_t  req_i,
  output fetch_pkg::imem_resp_t resp_o
);

  ////////////////////////////////////////////////////////////////////
  // Program storage
  ////////////////////////////////////////////////////////////////////

  logic [fetch_pkg::InstrLen-1:0] rom [2**fetch_pkg::ImemAddrBits];

  initial begin
    $readmemh("program.hex", rom);
  end

  // Only the word index reaches the ROM, so the byte address wraps every 64 bytes.
  logic [fetch_pkg::ImemAddrBits-1:0] word_idx;

  assign word_idx = req_i.pc[fetch_pkg::ImemAddrBits+1:2];

  ////////////////////////////////////////////////////////////////////
  // Response register
  ////////////////////////////////////////////////////////////////////

  logic                           valid_q;
  logic [fetch_pkg::InstrLen-1:0] instr_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= req_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    instr_q <= rom[word_idx];
  end

  assign resp_o = '{valid: valid_q, instr: instr_q};

  // The low two address bits never reach the ROM, so a request must be word aligned.
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i.valid |-> (req_i.pc[1:0] == 2'b00));

endmodule

// ==== hdl/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          redirect_valid_i,
  input  logic [fetch_pkg::AddrLen-1:0] redirect_pc_i,
  input  fetch_pkg::branch_info_t       branch_info_i,
  output logic                          fetch_valid_o,
  input  logic                          fetch_ready_i,
  output fetch_pkg::fetched_instr_t     fetch_instr_o
);

  // Memory bus between the frontend and the ROM.
  fetch_pkg::imem_req_t  imem_req;
  fetch_pkg::imem_resp_t imem_resp;

  fetch_frontend frontend (
    .clk_i,
    .rst_ni,
    .imem_req_o       (imem_req),
    .imem_resp_i      (imem_resp),
    .redirect_valid_i,
    .redirect_pc_i,
    .branch_info_i,
    .fetch_valid_o,
    .fetch_ready_i,
    .fetch_instr_o
  );

  fetch_imem imem (
    .clk_i,
    .rst_ni,
    .req_i  (imem_req),
    .resp_o (imem_resp)
  );

endmodule

// ==== bench/fetch_tb.sv ====
`timescale 1ns/1ps

module fetch_tb;

  // The tests take a few hundred cycles together, so this leaves a wide margin.
  localparam int unsigned TimeoutCycles = 2000;
  // Longest wait for a single delivered item, random stalls included.
  localparam int unsigned MaxWait = 64;

  logic                          clk_i;
  logic                          rst_ni;
  logic                          redirect_valid_i;
  logic [fetch_pkg::AddrLen-1:0] redirect_pc_i;
  fetch_pkg::branch_info_t       branch_info_i;
  logic                          fetch_valid_o;
  logic                          fetch_ready_i;
  fetch_pkg::fetched_instr_t     fetch_instr_o;

  // Copy of the program, used to work out the expected instruction word.
  logic [31:0]                   prog [16];
  logic [31:0]                   lfsr;
  logic                          random_stall;
  logic [fetch_pkg::AddrLen-1:0] exp_pc;
  int unsigned                   error_count;
  int unsigned                   check_count;
  int unsigned                   cycle_count;

  fetch_top dut0 (
    .clk_i,
    .rst_ni,
    .redirect_valid_i,
    .redirect_pc_i,
    .branch_info_i,
    .fetch_valid_o,
    .fetch_ready_i,
    .fetch_instr_o
  );

  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_count = cycle_count + 1;
    if (cycle_count == TimeoutCycles) begin
      $display("Timeout after %0d cycles, the fetch tests did not finish", cycle_count);
      $display("Simulation failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  // Taps 32, 22, 2 and 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
  endfunction

  task automatic check_eq(input logic [63:0] actual, input logic [63:0] expected,
                          input string what);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("CHECK FAILED at %0t ns: %s, got %0h, expected %0h",
               $time, what, actual, expected);
    end
  endtask

  // Moves to just after the next rising edge and sets the ready for that cycle.
  task automatic drive_cycle();
    logic ready;
    ready = 1'b1;
    if (random_stall) begin
      lfsr  = lfsr_step(lfsr);
      ready = lfsr[0];
    end
    @(posedge clk_i);
    #2;
    redirect_valid_i = 1'b0;
    fetch_ready_i    = ready;
  endtask

  // Outputs are sampled on the falling edge, where they are stable.
  // A stalled item must still be there, unchanged, one cycle later.
  task automatic take_item(output fetch_pkg::fetched_instr_t item, output logic ok);
    logic                      held;
    fetch_pkg::fetched_instr_t held_item;
    int unsigned               waited;
    held      = 1'b0;
    held_item = '0;
    item      = '0;
    ok        = 1'b0;
    waited    = 0;
    while (!ok && waited < MaxWait) begin
      drive_cycle();
      @(negedge clk_i);
      if (held) begin
        check_eq(64'(fetch_valid_o), 64'(1), "valid dropped during a stall");
        check_eq(64'(fetch_instr_o), 64'(held_item), "output changed during a stall");
      end
      held      = fetch_valid_o && !fetch_ready_i;
      held_item = fetch_instr_o;
      if (fetch_valid_o && fetch_ready_i) begin
        item = fetch_instr_o;
        ok   = 1'b1;
      end
      waited++;
    end
    if (!ok) begin
      error_count++;
      $display("ERROR at %0t ns: no instruction was delivered within %0d cycles",
               $time, MaxWait);
    end
  endtask

  task automatic expect_item(input logic [fetch_pkg::AddrLen-1:0] pc,
                             input fetch_pkg::fetch_reason_e reason);
    fetch_pkg::fetched_instr_t item;
    logic                      ok;
    take_item(item, ok);
    if (ok) begin
      check_eq(64'(item.pc), 64'(pc), "pc of delivered item");
      check_eq(64'(item.reason), 64'(reason), $sformatf("reason at pc %0h", pc));
      check_eq(64'(item.instr), 64'(prog[pc[5:2]]), $sformatf("instr at pc %0h", pc));
    end
  endtask

  // Plain sequential fetch with no predicted branch on the way.
  task automatic follow_sequence(input int unsigned count);
    for (int unsigned i = 0; i < count; i++) begin
      expect_item(exp_pc, fetch_pkg::FETCH_PREFETCH);
      exp_pc = exp_pc + 16'd4;
    end
  endtask

  task automatic send_redirect(input logic [fetch_pkg::AddrLen-1:0] target,
                               input fetch_pkg::branch_type_e btype,
                               input logic [fetch_pkg::AddrLen-1:0] branch_pc);
    @(posedge clk_i);
    #2;
    redirect_valid_i = 1'b1;
    redirect_pc_i    = target;
    branch_info_i    = '{branch_type: btype, pc: branch_pc};
    fetch_ready_i    = 1'b0;
    @(negedge clk_i);
  endtask

  // The redirect discards everything older, so the next delivered item is the redirected one.
  task automatic expect_redirect_item(input logic [fetch_pkg::AddrLen-1:0] pc);
    expect_item(pc, fetch_pkg::FETCH_REDIRECT);
    exp_pc = pc + 16'd4;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset_fetch();
    expect_item(16'h0000, fetch_pkg::FETCH_REDIRECT);
    exp_pc = 16'h0004;
    follow_sequence(19);
  endtask

  task automatic test_back_pressure();
    random_stall = 1'b1;
    follow_sequence(40);
    random_stall = 1'b0;
  endtask

  task automatic test_redirect();
    random_stall = 1'b1;
    send_redirect(16'h0020, fetch_pkg::BRANCH_NONE, 16'h0000);
    expect_redirect_item(16'h0020);
    follow_sequence(12);
    random_stall = 1'b0;
  endtask

  // The jump at 0x08 stays in the BTB for the rest of the run.
  task automatic test_jump_prediction();
    send_redirect(16'h0030, fetch_pkg::BRANCH_JUMP, 16'h0008);
    expect_redirect_item(16'h0030);
    send_redirect(16'h0000, fetch_pkg::BRANCH_NONE, 16'h0000);
    expect_redirect_item(16'h0000);
    expect_item(16'h0004, fetch_pkg::FETCH_PREFETCH);
    expect_item(16'h0008, fetch_pkg::FETCH_PREFETCH);
    expect_item(16'h0030, fetch_pkg::FETCH_PREDICT);
    expect_item(16'h0034, fetch_pkg::FETCH_PREFETCH);
  endtask

  // Fetch restarts at 0x0c each time so that it reaches 0x10 before the jump at 0x08.
  task automatic test_branch_direction();
    send_redirect(16'h0004, fetch_pkg::BRANCH_TAKEN, 16'h0010);
    expect_redirect_item(16'h0004);
    send_redirect(16'h000c, fetch_pkg::BRANCH_NONE, 16'h0000);
    expect_redirect_item(16'h000c);
    expect_item(16'h0010, fetch_pkg::FETCH_PREFETCH);
    expect_item(16'h0004, fetch_pkg::FETCH_PREDICT);
    send_redirect(16'h0014, fetch_pkg::BRANCH_UNTAKEN, 16'h0010);
    expect_redirect_item(16'h0014);
    send_redirect(16'h0014, fetch_pkg::BRANCH_UNTAKEN, 16'h0010);
    expect_redirect_item(16'h0014);
    send_redirect(16'h000c, fetch_pkg::BRANCH_NONE, 16'h0000);
    expect_redirect_item(16'h000c);
    expect_item(16'h0010, fetch_pkg::FETCH_PREFETCH);
    expect_item(16'h0014, fetch_pkg::FETCH_PREFETCH);
  endtask

  initial begin
    clk_i            = 1'b0;
    rst_ni           = 1'b0;
    redirect_valid_i = 1'b0;
    redirect_pc_i    = '0;
    branch_info_i    = '0;
    fetch_ready_i    = 1'b0;
    lfsr             = 32'hd0ac;
    random_stall     = 1'b0;
    exp_pc           = '0;
    error_count      = 0;
    check_count      = 0;
    cycle_count      = 0;
    $readmemh("program.hex", prog);

    repeat (10) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_eq(64'(fetch_valid_o), 64'(0), "valid right after reset");

    test_reset_fetch();
    test_back_pressure();
    test_redirect();
    test_jump_prediction();
    test_branch_direction();

    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== program.hex ====
// One 32-bit instruction word per line, for word addresses 0 to 15.
00100093
00200113
00300193
00400213
00500293
00600313
00700393
00800413
00900493
00a00513
00b00593
00c00613
00d00693
00e00713
00f00793
01000813

// ==== sim.f ====
hdl/fetch_pkg.sv
hdl/fetch_btb.sv
hdl/fetch_bimodal.sv
hdl/fetch_frontend.sv
hdl/fetch_imem.sv
hdl/fetch_top.sv
bench/fetch_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the fetch frontend testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module fetch_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vfetch_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Simulation passed"; then
  exit 0
fi
exit 1
